// ==== hdl/fg_pkg.sv ====
`default_nettype none

package fg_pkg;

   // column index width, enough for up to 512 columns
   localparam int X_W = 9;
   // row index width
   localparam int Y_W = 8;

   // pixels held by one memory word
   localparam int WORD_BITS = 32;
   // low column bits that pick the pixel inside a word
   localparam int BIT_W = $clog2(WORD_BITS);

   // one enable bit per pixel, bit 0 is the leftmost pixel of the word
   typedef logic [WORD_BITS-1:0] fg_word_t;

   // pixel position on the plane
   typedef struct packed {
      logic [X_W-1:0] x;
      logic [Y_W-1:0] y;
   } pix_pos_t;

   // single pixel write from the filler
   typedef struct packed {
      pix_pos_t pos;
      logic     enable;
   } fg_wr_t;

   // rectangle fill, corners are inclusive
   typedef struct packed {
      logic [X_W-1:0] x0;
      logic [Y_W-1:0] y0;
      logic [X_W-1:0] x1;
      logic [Y_W-1:0] y1;
      logic           enable;
   } fill_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/fg_en_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_en_ram #(
   parameter int DEPTH = 32
) (
   input  wire                     clk,
   input  wire [$clog2(DEPTH)-1:0] addr,
   input  wire                     wren,
   input  fg_pkg::fg_word_t        wdata,
   output fg_pkg::fg_word_t        rdata
);

   import fg_pkg::*;

   // enable plane storage, one word per 32 pixels
   fg_word_t mem [DEPTH];

   // write port, takes the merged word from the controller
   always_ff @(posedge clk) begin
      if (wren) begin
         mem[addr] <= wdata;
      end
   end

   // registered read, data shows up one cycle after addr
   // read during write returns the old word
   always_ff @(posedge clk) begin
      rdata <= mem[addr];
   end

endmodule

`default_nettype wire

// ==== hdl/fg_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_controller #(
   parameter int COLS  = 64,
   parameter int DEPTH = 32
) (
   input  wire                      clk,
   input  wire                      arst_n,
   // scan side
   input  wire                      drawing,
   input  fg_pkg::pix_pos_t         rd_pos,
   output logic                     rd_value,
   output logic                     mismatch_pause,
   // fill side
   input  wire                      wr,
   input  fg_pkg::fg_wr_t           wr_data,
   output logic                     wr_stall,
   // memory port
   output logic [$clog2(DEPTH)-1:0] addr,
   output logic                     wren,
   output fg_pkg::fg_word_t         wdata,
   input  fg_pkg::fg_word_t         rdata
);

   import fg_pkg::*;

   localparam int AW            = $clog2(DEPTH);
   localparam int WORDS_PER_ROW = COLS / WORD_BITS;

   pix_pos_t          sel_pos;
   logic [AW-1:0]     sel_addr;
   logic [BIT_W-1:0]  bit_sel;
   logic              miss;

   // cached word and where it came from
   logic [AW-1:0]     cur_addr;
   fg_word_t          cur_word;
   fg_word_t          next_word;

   // fetch in flight, address captured when the read went out
   logic              pend;
   logic [AW-1:0]     fetch_addr;

   // display owns the port for the whole scan
   assign sel_pos = drawing ? rd_pos : wr_data.pos;

   // row times words per row, plus the word part of the column
   assign sel_addr = AW'(sel_pos.y * WORDS_PER_ROW + sel_pos.x[X_W-1:BIT_W]);
   assign bit_sel  = sel_pos.x[BIT_W-1:0];

   assign miss = (sel_addr != cur_addr);

   // hold both sides until the fetched word lands
   // pend keeps the pause up even if the address moved while in flight
   assign mismatch_pause = miss || pend;
   assign wr_stall       = drawing || mismatch_pause;

   // write through only while the cached word is the one addressed
   assign wren = wr && !drawing && !mismatch_pause;
   assign addr = sel_addr;

   // replace one bit of the cached word with the requested enable
   always_comb begin
      next_word          = cur_word;
      next_word[bit_sel] = wr_data.enable;
   end

   assign wdata = next_word;

   // pixel under the scanner
   assign rd_value = cur_word[rd_pos.x[BIT_W-1:0]];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend       <= 1'b0;
         fetch_addr <= '0;
         cur_addr   <= '0;
         cur_word   <= '0;
      end else begin
         // single read per mismatch, rdata returns next cycle
         pend <= miss && !pend;
         if (miss && !pend) begin
            fetch_addr <= sel_addr;
         end
         if (pend) begin
            // fetch returned, if the address moved meanwhile the
            // compare misses again and a new fetch starts
            cur_addr <= fetch_addr;
            cur_word <= rdata;
         end else if (wren) begin
            cur_word <= next_word;
         end
      end
   end

   // a write goes out only with the scan idle and the port on the cached word
   a_wren_safe : assert property (
      @(posedge clk) disable iff (!arst_n)
      wren |-> !drawing && !pend && (addr == cur_addr)
   );

   // the tag moves only on a returning fetch
   a_tag_on_fetch : assert property (
      @(posedge clk) disable iff (!arst_n)
      !$stable(cur_addr) |-> $past(pend)
   );

endmodule

`default_nettype wire

// ==== hdl/rect_filler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rect_filler (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               fill_start,
   input  fg_pkg::fill_cmd_t fill_cmd,
   output logic              fill_busy,
   output logic              wr,
   output fg_pkg::fg_wr_t    wr_data,
   input  wire               wr_stall
);

   import fg_pkg::*;

   // latched command and the walking position
   fill_cmd_t       cmd;
   logic [X_W-1:0]  x;
   logic [Y_W-1:0]  y;
   logic            busy;
   logic            accept;
   logic            row_end;
   logic            last;

   // a pixel goes out every busy cycle, it counts once not stalled
   assign accept  = busy && !wr_stall;
   assign row_end = (x == cmd.x1);
   assign last    = row_end && (y == cmd.y1);

   assign fill_busy      = busy;
   assign wr             = busy;
   assign wr_data.pos.x  = x;
   assign wr_data.pos.y  = y;
   assign wr_data.enable = cmd.enable;

   // command payload, loaded only while idle
   always_ff @(posedge clk) begin
      if (fill_start && !busy) begin
         cmd <= fill_cmd;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= 1'b0;
         x    <= '0;
         y    <= '0;
      end else if (!busy) begin
         // new rectangle starts at its top left corner
         if (fill_start) begin
            busy <= 1'b1;
            x    <= fill_cmd.x0;
            y    <= fill_cmd.y0;
         end
      end else if (accept) begin
         if (last) begin
            // corner (x1, y1) written
            busy <= 1'b0;
         end else if (row_end) begin
            x <= cmd.x0;
            y <= y + 1'b1;
         end else begin
            x <= x + 1'b1;
         end
      end
   end

   // walk relies on ordered corners
   a_cmd_ordered : assert property (
      @(posedge clk) disable iff (!arst_n)
      busy |-> (cmd.x0 <= cmd.x1) && (cmd.y0 <= cmd.y1)
   );

endmodule

`default_nettype wire

// ==== hdl/scan_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_reader #(
   parameter int COLS = 64,
   parameter int ROWS = 16
) (
   input  wire              clk,
   input  wire              arst_n,
   input  wire              scan_start,
   output logic             drawing,
   output fg_pkg::pix_pos_t rd_pos,
   input  wire              rd_value,
   input  wire              mismatch_pause,
   output logic             pix_valid,
   output fg_pkg::pix_pos_t pix_pos,
   output logic             pix_value,
   output logic             scan_done
);

   import fg_pkg::*;

   // raster counters
   logic [X_W-1:0] x;
   logic [Y_W-1:0] y;
   logic           step;
   logic           last;
   logic           last_q;

   assign rd_pos.x = x;
   assign rd_pos.y = y;

   // advance only while the controller holds the right word
   assign step = drawing && !mismatch_pause;
   assign last = (x == X_W'(COLS - 1)) && (y == Y_W'(ROWS - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         drawing   <= 1'b0;
         x         <= '0;
         y         <= '0;
         pix_valid <= 1'b0;
         last_q    <= 1'b0;
         scan_done <= 1'b0;
      end else begin
         pix_valid <= step;
         last_q    <= step && last;
         // done one cycle after the last strobe
         scan_done <= last_q;
         if (!drawing) begin
            // restart from the top left, start during a scan is dropped
            if (scan_start) begin
               drawing <= 1'b1;
               x       <= '0;
               y       <= '0;
            end
         end else if (step) begin
            if (last) begin
               drawing <= 1'b0;
            end else if (x == X_W'(COLS - 1)) begin
               x <= '0;
               y <= y + 1'b1;
            end else begin
               x <= x + 1'b1;
            end
         end
      end
   end

   // pixel payload, qualified by pix_valid
   always_ff @(posedge clk) begin
      if (step) begin
         pix_pos   <= rd_pos;
         pix_value <= rd_value;
      end
   end

   a_pos_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      pix_valid |-> (pix_pos.x < COLS) && (pix_pos.y < ROWS)
   );

endmodule

`default_nettype wire

// ==== hdl/fg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_top #(
   parameter int COLS = 64,
   parameter int ROWS = 16
) (
   input  wire               clk,
   input  wire               arst_n,
   input  wire               fill_start,
   input  fg_pkg::fill_cmd_t fill_cmd,
   output logic              fill_busy,
   input  wire               scan_start,
   output logic              pix_valid,
   output fg_pkg::pix_pos_t  pix_pos,
   output logic              pix_value,
   output logic              scan_done
);

   import fg_pkg::*;

   // words in the plane
   localparam int DEPTH = ROWS * (COLS / WORD_BITS);
   localparam int AW    = $clog2(DEPTH);

   // filler to controller
   logic          wr;
   fg_wr_t        wr_data;
   logic          wr_stall;
   // scanner to controller
   logic          drawing;
   pix_pos_t      rd_pos;
   logic          rd_value;
   logic          mismatch_pause;
   // controller to memory
   logic [AW-1:0] addr;
   logic          wren;
   fg_word_t      wdata;
   fg_word_t      rdata;

   rect_filler u_filler (
      .clk        (clk),
      .arst_n     (arst_n),
      .fill_start (fill_start),
      .fill_cmd   (fill_cmd),
      .fill_busy  (fill_busy),
      .wr         (wr),
      .wr_data    (wr_data),
      .wr_stall   (wr_stall)
   );

   fg_controller #(.COLS(COLS), .DEPTH(DEPTH)) u_ctrl (
      .clk            (clk),
      .arst_n         (arst_n),
      .drawing        (drawing),
      .rd_pos         (rd_pos),
      .rd_value       (rd_value),
      .mismatch_pause (mismatch_pause),
      .wr             (wr),
      .wr_data        (wr_data),
      .wr_stall       (wr_stall),
      .addr           (addr),
      .wren           (wren),
      .wdata          (wdata),
      .rdata          (rdata)
   );

   fg_en_ram #(.DEPTH(DEPTH)) u_ram (
      .clk   (clk),
      .addr  (addr),
      .wren  (wren),
      .wdata (wdata),
      .rdata (rdata)
   );

   scan_reader #(.COLS(COLS), .ROWS(ROWS)) u_scan (
      .clk            (clk),
      .arst_n         (arst_n),
      .scan_start     (scan_start),
      .drawing        (drawing),
      .rd_pos         (rd_pos),
      .rd_value       (rd_value),
      .mismatch_pause (mismatch_pause),
      .pix_valid      (pix_valid),
      .pix_pos        (pix_pos),
      .pix_value      (pix_value),
      .scan_done      (scan_done)
   );

endmodule

`default_nettype wire

// ==== sim/fg_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fg_top_tb;

   import fg_pkg::*;

   localparam int COLS = 64;
   localparam int ROWS = 16;

   logic      clk;
   logic      arst_n;
   logic      fill_start;
   fill_cmd_t fill_cmd;
   logic      fill_busy;
   logic      scan_start;
   logic      pix_valid;
   pix_pos_t  pix_pos;
   logic      pix_value;
   logic      scan_done;

   // expected plane, updated by the fill rule
   logic ref_map [ROWS][COLS];
   // fill still running while a scan reads the plane
   logic      pend_on = 1'b0;
   fill_cmd_t pend_cmd;
   // a pending-rectangle pixel already showed its old value
   logic      seen_old = 1'b0;
   logic [X_W-1:0] exp_x = '0;
   logic [Y_W-1:0] exp_y = '0;
   int pix_count = 0;
   logic [31:0] lfsr_state = 32'hf8108eaf;
   int errors = 0;
   int errors_at_start = 0;
   int test_no = 1;
   int passed = 0;
   int failed = 0;
   logic timed_out = 1'b0;

   fg_top #(.COLS(COLS), .ROWS(ROWS)) DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .fill_start (fill_start),
      .fill_cmd   (fill_cmd),
      .fill_busy  (fill_busy),
      .scan_start (scan_start),
      .pix_valid  (pix_valid),
      .pix_pos    (pix_pos),
      .pix_value  (pix_value),
      .scan_done  (scan_done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // galois step, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
   endtask

   function automatic logic in_pend(input pix_pos_t p);
      return pend_on && p.x >= pend_cmd.x0 && p.x <= pend_cmd.x1
         && p.y >= pend_cmd.y0 && p.y <= pend_cmd.y1;
   endfunction

   // inside a pending fill the new value may only show as a raster prefix
   function automatic logic value_ok(input pix_pos_t p, input logic v, input logic old_seen);
      logic exp_v;
      exp_v = ref_map[p.y][p.x];
      if (!in_pend(p)) begin
         return v == exp_v;
      end
      return (v == exp_v) || (v == pend_cmd.enable && !old_seen);
   endfunction

   // scan tracking, restarted by each scan strobe
   always @(posedge clk) begin
      if (scan_start) begin
         seen_old <= 1'b0;
         exp_x    <= '0;
         exp_y    <= '0;
      end else if (pix_valid) begin
         pix_count <= pix_count + 1;
         if (in_pend(pix_pos) && pix_value != pend_cmd.enable) begin
            seen_old <= 1'b1;
         end
         if (exp_x == X_W'(COLS - 1)) begin
            exp_x <= '0;
            exp_y <= exp_y + Y_W'(1);
         end else begin
            exp_x <= exp_x + X_W'(1);
         end
      end
   end

   a_value : assert property (@(posedge clk) disable iff (!arst_n)
      pix_valid |-> value_ok(pix_pos, pix_value, seen_old))
      else begin
         errors++;
         $display("ERR %0t: pixel (%0d,%0d) value %0b not expected", $time,
            pix_pos.x, pix_pos.y, pix_value);
      end

   a_raster : assert property (@(posedge clk) disable iff (!arst_n)
      pix_valid |-> (pix_pos.x == exp_x && pix_pos.y == exp_y))
      else begin
         errors++;
         $display("ERR %0t: pixel at (%0d,%0d), raster order wants (%0d,%0d)", $time,
            pix_pos.x, pix_pos.y, exp_x, exp_y);
      end

   a_done_after_last : assert property (@(posedge clk) disable iff (!arst_n)
      (pix_valid && pix_pos.x == X_W'(COLS - 1) && pix_pos.y == Y_W'(ROWS - 1))
      |=> scan_done)
      else begin
         errors++;
         $display("ERR %0t: scan_done missing after the last pixel", $time);
      end

   a_done_only_last : assert property (@(posedge clk) disable iff (!arst_n)
      scan_done |-> $past(pix_valid && pix_pos.x == X_W'(COLS - 1)
                          && pix_pos.y == Y_W'(ROWS - 1)))
      else begin
         errors++;
         $display("ERR %0t: scan_done without a last pixel before it", $time);
      end

   task automatic apply_rect(input int x0, y0, x1, y1, input logic en);
      for (int y = y0; y <= y1; y++) begin
         for (int x = x0; x <= x1; x++) begin
            ref_map[y][x] = en;
         end
      end
   endtask

   task automatic start_fill(input int x0, y0, x1, y1, input logic en);
      @(negedge clk);
      fill_cmd.x0     = X_W'(x0);
      fill_cmd.y0     = Y_W'(y0);
      fill_cmd.x1     = X_W'(x1);
      fill_cmd.y1     = Y_W'(y1);
      fill_cmd.enable = en;
      fill_start      = 1'b1;
      @(negedge clk);
      fill_start = 1'b0;
   endtask

   task automatic wait_fill_idle(input int limit);
      int n;
      n = 0;
      while (fill_busy && n < limit && !timed_out) begin
         @(negedge clk);
         n++;
      end
      if (fill_busy && !timed_out) begin
         timed_out = 1'b1;
         $display("timeout: fill still busy after %0d cycles", limit);
      end
   endtask

   task automatic fill_rect(input int x0, y0, x1, y1, input logic en);
      start_fill(x0, y0, x1, y1, en);
      // each pixel costs at most a fetch plus the write
      wait_fill_idle(4 * (x1 - x0 + 1) * (y1 - y0 + 1) + 64);
      apply_rect(x0, y0, x1, y1, en);
   endtask

   task automatic run_scan();
      int n;
      int base;
      base = pix_count;
      @(negedge clk);
      scan_start = 1'b1;
      @(negedge clk);
      scan_start = 1'b0;
      n = 0;
      while (!scan_done && n < 4 * COLS * ROWS && !timed_out) begin
         @(negedge clk);
         n++;
      end
      if (!timed_out && !scan_done) begin
         timed_out = 1'b1;
         $display("timeout: scan did not finish within %0d cycles", 4 * COLS * ROWS);
      end else if (!timed_out) begin
         a_count : assert (pix_count - base == COLS * ROWS)
            else begin
               errors++;
               $display("ERR %0t: scan gave %0d pixels, expected %0d", $time,
                  pix_count - base, COLS * ROWS);
            end
      end
   endtask

   task automatic random_fill();
      int a;
      int b;
      int c;
      int d;
      int e;
      rand_bits(X_W, a);
      rand_bits(X_W, b);
      rand_bits(Y_W, c);
      rand_bits(Y_W, d);
      rand_bits(1, e);
      a = a % COLS;
      b = b % COLS;
      c = c % ROWS;
      d = d % ROWS;
      fill_rect(a < b ? a : b, c < d ? c : d, a < b ? b : a, c < d ? d : c, e[0]);
   endtask

   // single pixel at each screen corner
   task automatic fill_corners(input logic en);
      for (int i = 0; i < 4; i++) begin
         fill_rect(i[0] ? COLS - 1 : 0, i[1] ? ROWS - 1 : 0,
                   i[0] ? COLS - 1 : 0, i[1] ? ROWS - 1 : 0, en);
      end
   endtask

   task automatic end_test(input string name);
      if (errors == errors_at_start && !timed_out) begin
         passed++;
         $display("test %0d %s: pass", test_no, name);
      end else begin
         failed++;
         $display("test %0d %s: fail, %0d errors", test_no, name, errors - errors_at_start);
      end
      test_no++;
      errors_at_start = errors;
   endtask

   initial begin
      arst_n     = 1'b0;
      fill_start = 1'b0;
      fill_cmd   = '0;
      scan_start = 1'b0;
      pend_cmd   = '0;
      repeat (3) @(negedge clk);
      arst_n = 1'b1;
      a_reset_idle : assert (!fill_busy && !pix_valid && !scan_done)
         else begin
            errors++;
            $display("ERR %0t: outputs not idle after reset", $time);
         end

      fill_rect(0, 0, COLS - 1, ROWS - 1, 1'b0);
      run_scan();
      end_test("full clear");

      // crosses the word boundary at column 32
      fill_rect(20, 3, 45, 9, 1'b1);
      run_scan();
      end_test("boundary rectangle");

      fill_rect(30, 5, 55, 12, 1'b0);
      run_scan();
      end_test("overlapping clear");

      // scan arrives while the filler is still walking
      pend_cmd.x0     = X_W'(10);
      pend_cmd.y0     = Y_W'(1);
      pend_cmd.x1     = X_W'(50);
      pend_cmd.y1     = Y_W'(6);
      pend_cmd.enable = 1'b1;
      pend_on = 1'b1;
      start_fill(10, 1, 50, 6, 1'b1);
      repeat (3) @(negedge clk);
      run_scan();
      wait_fill_idle(4 * 41 * 6 + 64);
      apply_rect(10, 1, 50, 6, 1'b1);
      pend_on = 1'b0;
      run_scan();
      end_test("scan during fill");

      for (int i = 0; i < 5; i++) begin
         random_fill();
         run_scan();
      end
      end_test("random rectangles");

      fill_corners(1'b1);
      run_scan();
      fill_corners(1'b0);
      run_scan();
      end_test("corner pixels");

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
         test_no - 1, passed, failed, errors);
      if (errors == 0 && failed == 0 && !timed_out) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== fg_top.f ====
hdl/fg_pkg.sv
hdl/fg_en_ram.sv
hdl/fg_controller.sv
hdl/rect_filler.sv
hdl/scan_reader.sv
hdl/fg_top.sv
sim/fg_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fg_top testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
      --top-module fg_top_tb -f fg_top.f -o fg_top_sim; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/fg_top_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the testbench prints the pass line only when every check held
if echo "$out" | grep -q "^Simulation PASSED$"; then
   exit 0
fi
exit 1
